//--- filelist.f
common/z8IsaPkg.sv
common/z8CorePkg.sv
common/regFileIf.sv
common/aluIf.sv
core/z8Alu.sv
core/z8ProgramCounter.sv
core/z8RegisterFile.sv
core/z8Sequencer.sv
verilog/z8Top.sv
tb/z8Tb.sv

//--- tb/z8Tb.sv
`timescale 1ns/1ps
`default_nettype none

module z8Tb
    import z8IsaPkg::*, z8CorePkg::*;
();
    localparam int clkPeriod = 4;
    localparam int resetCycles = 16;
    localparam int numInstr = 200;
    // worst case 8 cycles per instruction, plus the closing jr loop, doubled
    localparam int watchdogNs = 2 * ((numInstr + 4) * 8 * clkPeriod + resetCycles * clkPeriod);

    logic clk = 1'b0;
    logic reset;
    byteT memData;
    pcT   memAddr;
    logic memStrobe;
    byteT port2;

    byteT progMem [65536];
    pcT   endAddr;
    int   errors;
    logic done;

    // expected strobes, in order, with the port2 value due at each fetch
    pcT   expAddr [$];
    logic expFetch [$];
    byteT expPort2 [$];

    // reference model state
    byteT mRegs [128];
    logic [3:0] mRp;
    byteT mFlags;
    byteT mPort2;

    z8Top dut0 (
        .clk       (clk),
        .reset     (reset),
        .memAddr   (memAddr),
        .memStrobe (memStrobe),
        .memData   (memData),
        .port2     (port2)
    );

    initial begin
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // program memory with one cycle of read latency
    always @(posedge clk) begin
        if (memStrobe) begin
            memData <= progMem[memAddr];
        end
    end

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // ============================================================
    // reference model
    // ============================================================
    function automatic int sizeOf(input byteT op);
        if (op[3:0] >= 4'hE) begin
            return 1;
        end
        if ((op[3:0] >= 4'h4 && op[3:0] <= 4'h7) || op[3:0] == 4'hD) begin
            return 3;
        end
        return 2;
    endfunction

    function automatic byteT modelRead(input logic [7:0] addr);
        if (!addr[7]) begin
            return mRegs[addr[6:0]];
        end
        if (addr == addrRp) begin
            return {mRp, 4'h0};
        end
        if (addr == addrFlags) begin
            return mFlags;
        end
        return 8'h00;
    endfunction

    task automatic modelWrite(input logic [7:0] addr, input byteT value);
        if (!addr[7]) begin
            mRegs[addr[6:0]] = value;
        end
        if (addr == addrRp) begin
            mRp = value[7:4];
        end
        if (addr == addrFlags) begin
            mFlags = value;
        end
        if (addr == addrPort2) begin
            mPort2 = value;
        end
    endtask

    function automatic logic [7:0] workAddr(input logic [3:0] r);
        return {mRp, r};
    endfunction

    // E-prefixed register addresses point at working registers
    function automatic logic [7:0] mapAddr(input logic [7:0] r);
        if (r[7:4] == workingPrefix) begin
            return workAddr(r[3:0]);
        end
        return r;
    endfunction

    function automatic logic condHolds(input logic [3:0] cc);
        logic c;
        logic z;
        logic s;
        logic v;
        logic base;
        c = mFlags[flagC];
        z = mFlags[flagZ];
        s = mFlags[flagS];
        v = mFlags[flagV];
        case (cc[2:0])
            3'd0:    base = 1'b0;
            3'd1:    base = s ^ v;
            3'd2:    base = (s ^ v) | z;
            3'd3:    base = c | z;
            3'd4:    base = v;
            3'd5:    base = s;
            3'd6:    base = z;
            default: base = c;
        endcase
        return base ^ cc[3];
    endfunction

    // two-operand group, high nibble selects the operation
    task automatic groupOp(input logic [3:0] hi, input byteT a, input byteT b,
                           input logic [7:0] dst);
        logic cin;
        logic [8:0] wide;
        int sres;
        byteT res;
        if (hi[3] && hi != 4'hA && hi != 4'hB) begin
            return;
        end
        cin = mFlags[flagC] && (hi == 4'h1 || hi == 4'h3);
        case (hi)
            4'h0, 4'h1: begin
                wide = {1'b0, a} + {1'b0, b} + {8'h00, cin};
                res = wide[7:0];
                // overflow when the signed sum leaves the byte range
                sres = $signed(a) + $signed(b) + int'(cin);
                mFlags[flagC] = wide > 9'd255;
                mFlags[flagV] = (sres > 127) || (sres < -128);
            end
            4'h2, 4'h3, 4'hA: begin
                res = a - b - {7'd0, cin};
                sres = $signed(a) - $signed(b) - int'(cin);
                mFlags[flagC] = {1'b0, a} < ({1'b0, b} + {8'h00, cin});
                mFlags[flagV] = (sres > 127) || (sres < -128);
            end
            4'h4: res = a | b;
            4'h5, 4'h7: res = a & b;
            4'h6: res = ~a & b;
            default: res = a ^ b;
        endcase
        if (hi >= 4'h4 && hi != 4'hA) begin
            mFlags[flagV] = 1'b0;
        end
        mFlags[flagZ] = res == 8'h00;
        mFlags[flagS] = res[7];
        // tcm, tm and cp leave the destination alone
        if (hi <= 4'h5 || hi == 4'hB) begin
            modelWrite(dst, res);
        end
    endtask

    task automatic pushStrobe(input pcT addr, input logic isFetch);
        expAddr.push_back(addr);
        expFetch.push_back(isFetch);
        expPort2.push_back(mPort2);
    endtask

    task automatic stepModel(inout pcT pc);
        byteT op;
        byteT b2;
        byteT b3;
        logic [3:0] hi;
        int size;
        pcT next;
        byteT a;
        byteT res;
        logic [7:0] dst;
        op = progMem[pc];
        b2 = progMem[pc + 16'd1];
        b3 = progMem[pc + 16'd2];
        hi = op[7:4];
        size = sizeOf(op);
        for (int k = 1; k < size; k++) begin
            pushStrobe(pc + 16'(k), 1'b0);
        end
        next = pc + 16'(size);
        case (op[3:0])
            4'hC: modelWrite(workAddr(hi), b2);
            4'h8: modelWrite(workAddr(hi), modelRead(mapAddr(b2)));
            4'h9: modelWrite(b2, modelRead(workAddr(hi)));
            4'h2: begin
                dst = workAddr(b2[7:4]);
                groupOp(hi, modelRead(dst), modelRead(workAddr(b2[3:0])), dst);
            end
            4'h6: groupOp(hi, modelRead(mapAddr(b2)), b3, mapAddr(b2));
            4'hE: begin
                dst = workAddr(hi);
                a = modelRead(dst);
                res = a + 8'd1;
                mFlags[flagV] = ($signed(a) + 1) > 127;
                mFlags[flagZ] = res == 8'h00;
                mFlags[flagS] = res[7];
                modelWrite(dst, res);
            end
            4'hA: begin
                dst = workAddr(hi);
                res = modelRead(dst) - 8'd1;
                modelWrite(dst, res);
                if (res != 8'h00) begin
                    next = next + {{8{b2[7]}}, b2};
                end
            end
            4'hB: if (condHolds(hi)) next = next + {{8{b2[7]}}, b2};
            4'hD: if (condHolds(hi)) next = {b2, b3};
            4'h1: if (hi == 4'h3) modelWrite(addrRp, b2);
            4'hF: begin
                if (hi == 4'hC) mFlags[flagC] = 1'b0;
                if (hi == 4'hD) mFlags[flagC] = 1'b1;
                if (hi == 4'hE) mFlags[flagC] = ~mFlags[flagC];
            end
            default: ;
        endcase
        pc = next;
    endtask

    // runs until the closing jr has been fetched three times
    task automatic runModel();
        pcT pc;
        int visits;
        for (int i = 0; i < 128; i++) begin
            mRegs[i] = 8'h00;
        end
        mRp = 4'h0;
        mFlags = 8'h00;
        mPort2 = 8'h00;
        pc = resetVector;
        visits = 0;
        while (visits < 3) begin
            pushStrobe(pc, 1'b1);
            if (pc == endAddr) visits++;
            if (visits < 3) stepModel(pc);
        end
    endtask

    // ============================================================
    // program generation
    // ============================================================
    function automatic byteT pickSource();
        if ($urandom % 2) begin
            return {workingPrefix, 4'($urandom)};
        end
        return {1'b0, 7'($urandom)};
    endfunction

    function automatic logic [3:0] pickGroup();
        int g;
        g = $urandom % 10;
        return (g < 8) ? 4'(g) : 4'(g + 2);
    endfunction

    task automatic generateProgram();
        pcT starts [$];
        int kinds [$];
        pcT addr;
        int kind;
        int j;
        pcT target;
        byteT op;
        logic [3:0] hi;
        addr = resetVector;
        for (int i = 0; i < numInstr; i++) begin
            kind = $urandom % 12;
            hi = 4'($urandom);
            starts.push_back(addr);
            kinds.push_back(kind);
            progMem[addr + 16'd1] = byteT'($urandom);
            progMem[addr + 16'd2] = byteT'($urandom);
            case (kind)
                0: op = {hi, 4'hC};
                1: begin
                    op = {hi, 4'h8};
                    progMem[addr + 16'd1] = pickSource();
                end
                2: begin
                    op = {hi, 4'h9};
                    progMem[addr + 16'd1] = ($urandom % 2) ? addrPort2 : {1'b0, 7'($urandom)};
                end
                3: op = {pickGroup(), 4'h2};
                4: begin
                    op = {pickGroup(), 4'h6};
                    progMem[addr + 16'd1] = pickSource();
                end
                5: op = {hi, 4'hE};
                6: op = {hi, 4'hA};
                7: op = {hi, 4'hB};
                8: op = {hi, 4'hD};
                9: begin
                    op = 8'h31;
                    if ($urandom % 2) progMem[addr + 16'd1] = 8'h00;
                end
                10: op = {2'b11, 2'($urandom), 4'hF};
                default: begin
                    // any opcode outside the branch columns
                    op = byteT'($urandom);
                    while (op[3:0] == 4'hA || op[3:0] == 4'hB || op[3:0] == 4'hD) begin
                        op = byteT'($urandom);
                    end
                end
            endcase
            progMem[addr] = op;
            addr = addr + 16'(sizeOf(op));
        end
        endAddr = addr;
        progMem[addr] = 8'h8B;
        progMem[addr + 16'd1] = 8'hFE;
        starts.push_back(addr);
        // branches land on a later instruction start
        for (int i = 0; i < numInstr; i++) begin
            if (kinds[i] >= 6 && kinds[i] <= 8) begin
                j = i + 1 + ($urandom % 4);
                if (j > numInstr) j = numInstr;
                target = starts[j];
                if (kinds[i] == 8) begin
                    progMem[starts[i] + 16'd1] = target[15:8];
                    progMem[starts[i] + 16'd2] = target[7:0];
                end else begin
                    progMem[starts[i] + 16'd1] = byteT'(target - (starts[i] + 16'd2));
                end
            end
        end
    endtask

    // ============================================================
    // checks and run control
    // ============================================================
    always @(negedge clk) begin : strobeCheck
        pcT expected;
        logic isFetch;
        byteT expectedPort2;
        if (reset) begin
            checkValue("memStrobe", 16'd0, {15'd0, memStrobe});
        end else if (memStrobe && !done) begin
            if (expAddr.size() == 0) begin
                $display("unexpected strobe at address %h after the program ended", memAddr);
                errors++;
                done = 1'b1;
            end else begin
                expected = expAddr.pop_front();
                isFetch = expFetch.pop_front();
                expectedPort2 = expPort2.pop_front();
                checkValue("memAddr", expected, memAddr);
                if (isFetch) begin
                    checkValue("port2", {8'h00, expectedPort2}, {8'h00, port2});
                end
                if (expAddr.size() == 0) done = 1'b1;
            end
        end
    end

    initial begin
        reset = 1'b1;
        memData = 8'h00;
        errors = 0;
        done = 1'b0;
        void'($urandom(8091));
        for (int a = 0; a < 65536; a++) begin
            progMem[a] = byteT'(a ^ (a >> 8));
        end
        generateProgram();
        runModel();
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        wait (done);
        $display("run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("timeout after %0d ns before the program reached its end", watchdogNs);
        $display("run stopped with %0d errors", errors);
        $display("ERRORS FOUND");
        $finish;
    end
endmodule

`default_nettype wire

//--- verilog/z8Top.sv
`timescale 1ns/1ps
`default_nettype none

module z8Top
    import z8CorePkg::*;
(
    input  wire  clk,
    input  wire  reset,
    output pcT   memAddr,
    output logic memStrobe,
    input  wire byteT memData,
    output byteT port2
);
    logic pcInc;
    logic pcBranchRel;
    logic pcLoad;
    byteT branchOffset;
    pcT   jumpTarget;

    regFileIf rfBus ();
    aluIf     aluBus ();

    z8Sequencer seq0 (
        .clk          (clk),
        .reset        (reset),
        .memStrobe    (memStrobe),
        .memData      (memData),
        .pcInc        (pcInc),
        .pcBranchRel  (pcBranchRel),
        .pcLoad       (pcLoad),
        .branchOffset (branchOffset),
        .jumpTarget   (jumpTarget),
        .rf           (rfBus.seq),
        .alu          (aluBus.seq)
    );

    // the program counter addresses program memory directly
    z8ProgramCounter pc0 (
        .clk          (clk),
        .reset        (reset),
        .pcInc        (pcInc),
        .pcBranchRel  (pcBranchRel),
        .pcLoad       (pcLoad),
        .branchOffset (branchOffset),
        .jumpTarget   (jumpTarget),
        .pc           (memAddr)
    );

    z8RegisterFile regs0 (
        .clk   (clk),
        .reset (reset),
        .rf    (rfBus.regs),
        .alu   (aluBus.sink),
        .port2 (port2)
    );

    z8Alu alu0 (
        .alu   (aluBus.alu),
        .flags (rfBus.flags)
    );
endmodule

`default_nettype wire

//--- core/z8Sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module z8Sequencer
    import z8IsaPkg::*, z8CorePkg::*;
(
    input  wire   clk,
    input  wire   reset,
    output logic  memStrobe,
    input  wire byteT memData,
    output logic  pcInc,
    output logic  pcBranchRel,
    output logic  pcLoad,
    output byteT  branchOffset,
    output pcT    jumpTarget,
    regFileIf.seq rf,
    aluIf.seq     alu
);
    seqStateT state;
    seqStateT stateNext;
    // low for the first cycle out of reset
    logic running;

    byteT instr;
    byteT second;
    byteT third;
    logic [3:0] rpHigh;

    logic [3:0] instrH;
    logic [3:0] instrL;
    logic [3:0] secondH;
    logic [3:0] secondL;
    logic size1;
    logic size3;

    aluModeT groupMode;
    logic isGroupOp;
    logic groupWrites;

    aluModeT opMode;
    regAddrT addrA;
    regAddrT addrB;
    regAddrT destAddr;
    logic immA;
    logic immB;
    logic writesReg;
    logic writesFlags;
    logic isDjnz;
    logic needsExecute;

    logic condBase;
    logic condTrue;

    assign instrH  = instr[7:4];
    assign instrL  = instr[3:0];
    assign secondH = second[7:4];
    assign secondL = second[3:0];

    // columns E,F one byte; 4-7 and D three bytes
    assign size1 = instrL[3:1] == 3'b111;
    assign size3 = (instrL[3:2] == 2'b01) || (instrL == colJp);

    function automatic regAddrT workReg(input logic [3:0] r);
        return {rpHigh, r};
    endfunction

    function automatic regAddrT mapReg(input regAddrT r);
        if (r[7:4] == workingPrefix) begin
            return workReg(r[3:0]);
        end
        return r;
    endfunction

    // ============================================================
    // state register and instruction latches
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= stFetch;
            running <= 1'b0;
        end else begin
            state   <= stateNext;
            running <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            stReadInstr: instr  <= memData;
            stRead2:     second <= memData;
            stRead3:     third  <= memData;
            // port A holds RP during decode
            stDecode:    rpHigh <= rf.readDataA[7:4];
            default: ;
        endcase
    end

    always_comb begin
        stateNext = state;
        case (state)
            stFetch:     if (running) stateNext = stReadInstr;
            stReadInstr: stateNext = stWait2;
            stWait2:     stateNext = size1 ? stDecode : stRead2;
            stRead2:     stateNext = size3 ? stWait3 : stDecode;
            stWait3:     stateNext = stRead3;
            stRead3:     stateNext = stDecode;
            stDecode:    stateNext = needsExecute ? stExecute : stFetch;
            default:     stateNext = stFetch;
        endcase
    end

    // ============================================================
    // decode
    // ============================================================
    always_comb begin
        case (instrH)
            4'h0:    groupMode = aluAdd;
            4'h1:    groupMode = aluAdc;
            4'h2:    groupMode = aluSub;
            4'h3:    groupMode = aluSbc;
            4'h4:    groupMode = aluOr;
            4'h5:    groupMode = aluAnd;
            4'h6:    groupMode = aluTcm;
            4'h7:    groupMode = aluTm;
            4'hA:    groupMode = aluCp;
            default: groupMode = aluXor;
        endcase
        isGroupOp = !instrH[3] || (instrH == 4'hA) || (instrH == 4'hB);
        // tcm, tm and cp only touch flags
        groupWrites = (instrH[3:2] == 2'b00) || (instrH[3:1] == 3'b010) || (instrH == 4'hB);
    end

    always_comb begin
        opMode      = aluLoad;
        addrA       = workReg(instrH);
        addrB       = workReg(secondL);
        destAddr    = workReg(instrH);
        immA        = 1'b0;
        immB        = 1'b0;
        writesReg   = 1'b0;
        writesFlags = 1'b0;
        isDjnz      = 1'b0;
        case (instrL)
            colLdImm: begin
                immA      = 1'b1;
                writesReg = 1'b1;
            end
            colLdRegDir: begin
                addrA     = mapReg(second);
                writesReg = 1'b1;
            end
            colLdDirReg: begin
                // destination taken literally, no working register mapping
                destAddr  = second;
                writesReg = 1'b1;
            end
            colAluReg: begin
                addrA       = workReg(secondH);
                destAddr    = workReg(secondH);
                opMode      = groupMode;
                writesReg   = isGroupOp && groupWrites;
                writesFlags = isGroupOp;
            end
            colAluImm: begin
                addrA       = mapReg(second);
                destAddr    = mapReg(second);
                immB        = 1'b1;
                opMode      = groupMode;
                writesReg   = isGroupOp && groupWrites;
                writesFlags = isGroupOp;
            end
            colInc: begin
                opMode      = aluInc;
                writesReg   = 1'b1;
                writesFlags = 1'b1;
            end
            colDjnz: begin
                opMode    = aluDec;
                writesReg = 1'b1;
                isDjnz    = 1'b1;
            end
            colSrp: begin
                if (instrH == 4'h3) begin
                    immA      = 1'b1;
                    destAddr  = addrRp;
                    writesReg = 1'b1;
                end
            end
            colMisc: begin
                // rcf, scf, ccf
                writesFlags = instrH inside {4'hC, 4'hD, 4'hE};
                case (instrH)
                    4'hC:    opMode = aluClearCarry;
                    4'hD:    opMode = aluSetCarry;
                    default: opMode = aluComplementCarry;
                endcase
            end
            default: ;
        endcase
        needsExecute = writesReg || writesFlags;
    end

    // branch condition from FLAGS, bit 3 inverts
    always_comb begin
        case (condCodeT'({1'b0, instrH[2:0]}))
            ccLt:    condBase = rf.flags[flagS] ^ rf.flags[flagV];
            ccLe:    condBase = (rf.flags[flagS] ^ rf.flags[flagV]) | rf.flags[flagZ];
            ccUle:   condBase = rf.flags[flagC] | rf.flags[flagZ];
            ccOv:    condBase = rf.flags[flagV];
            ccMi:    condBase = rf.flags[flagS];
            ccZero:  condBase = rf.flags[flagZ];
            ccCarry: condBase = rf.flags[flagC];
            default: condBase = 1'b0;
        endcase
        condTrue = condBase ^ instrH[3];
    end

    // ============================================================
    // outputs
    // ============================================================
    assign memStrobe = ((state == stFetch) && running)
                     || ((state == stWait2) && !size1)
                     || (state == stWait3);

    assign pcInc       = state inside {stReadInstr, stRead2, stRead3};
    assign pcBranchRel = ((state == stDecode) && (instrL == colJr) && condTrue)
                      || ((state == stExecute) && isDjnz && (alu.result != 8'h00));
    assign pcLoad       = (state == stDecode) && (instrL == colJp) && condTrue;
    assign branchOffset = second;
    assign jumpTarget   = {second, third};

    always_comb begin
        rf.readAddrA   = (state == stDecode) ? addrRp : addrA;
        rf.readAddrB   = addrB;
        rf.writeAddr   = destAddr;
        rf.writeEnable = (state == stExecute) && writesReg;
        rf.flagsWrite  = (state == stExecute) && writesFlags;
        alu.mode       = opMode;
        alu.operandA   = immA ? second : rf.readDataA;
        alu.operandB   = immB ? third : rf.readDataB;
    end
endmodule

`default_nettype wire

//--- core/z8RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module z8RegisterFile
    import z8IsaPkg::*, z8CorePkg::*;
(
    input  wire    clk,
    input  wire    reset,
    regFileIf.regs rf,
    aluIf.sink     alu,
    output byteT   port2
);
    byteT regs [numGeneralRegs];
    // only the upper nibble of RP exists
    logic [3:0] rp;
    byteT flagsQ;

    function automatic byteT readReg(input regAddrT addr);
        byteT value;
        if (!addr[7]) begin
            value = regs[addr[6:0]];
        end else if (addr == addrRp) begin
            value = {rp, 4'h0};
        end else if (addr == addrFlags) begin
            value = flagsQ;
        end else begin
            value = 8'h00;
        end
        return value;
    endfunction

    assign rf.readDataA = readReg(rf.readAddrA);
    assign rf.readDataB = readReg(rf.readAddrB);
    assign rf.flags     = flagsQ;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numGeneralRegs; i++) begin
                regs[i] <= 8'h00;
            end
            rp     <= 4'h0;
            flagsQ <= 8'h00;
            port2  <= 8'h00;
        end else begin
            if (rf.flagsWrite) begin
                flagsQ <= alu.flagsOut;
            end
            // a direct write to FLAGS overrides the ALU flags
            if (rf.writeEnable) begin
                if (!rf.writeAddr[7]) begin
                    regs[rf.writeAddr[6:0]] <= alu.result;
                end
                if (rf.writeAddr == addrRp) begin
                    rp <= alu.result[7:4];
                end
                if (rf.writeAddr == addrFlags) begin
                    flagsQ <= alu.result;
                end
                if (rf.writeAddr == addrPort2) begin
                    port2 <= alu.result;
                end
            end
        end
    end
endmodule

`default_nettype wire

//--- core/z8ProgramCounter.sv
`timescale 1ns/1ps
`default_nettype none

module z8ProgramCounter
    import z8IsaPkg::*, z8CorePkg::*;
(
    input  wire  clk,
    input  wire  reset,
    input  wire  pcInc,
    input  wire  pcBranchRel,
    input  wire  pcLoad,
    input  wire byteT branchOffset,
    input  wire pcT   jumpTarget,
    output pcT   pc
);
    pcT relTarget;

    // pc already points past the branch instruction
    assign relTarget = pc + {{8{branchOffset[7]}}, branchOffset};

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
        end else if (pcLoad) begin
            pc <= jumpTarget;
        end else if (pcBranchRel) begin
            pc <= relTarget;
        end else if (pcInc) begin
            pc <= pc + 16'd1;
        end
    end
endmodule

`default_nettype wire

//--- core/z8Alu.sv
`timescale 1ns/1ps
`default_nettype none

module z8Alu
    import z8IsaPkg::*, z8CorePkg::*;
(
    aluIf.alu   alu,
    input wire byteT flags
);
    byteT a;
    byteT b;
    logic carryIn;
    logic [8:0] sum;
    logic [8:0] diff;
    byteT res;
    byteT newFlags;
    logic setZs;

    assign a = alu.operandA;
    assign b = alu.operandB;
    assign carryIn = flags[flagC] && (alu.mode == aluAdc || alu.mode == aluSbc);

    // bit 8 of diff is the borrow
    assign sum  = {1'b0, a} + {1'b0, b} + {8'h00, carryIn};
    assign diff = {1'b0, a} - {1'b0, b} - {8'h00, carryIn};

    always_comb begin
        res      = a;
        newFlags = flags;
        setZs    = 1'b1;
        case (alu.mode)
            aluAdd, aluAdc: begin
                res             = sum[7:0];
                newFlags[flagC] = sum[8];
                newFlags[flagV] = (a[7] == b[7]) && (res[7] != a[7]);
            end
            aluSub, aluSbc, aluCp: begin
                res             = diff[7:0];
                newFlags[flagC] = diff[8];
                newFlags[flagV] = (a[7] != b[7]) && (res[7] != a[7]);
            end
            aluInc: begin
                res             = a + 8'd1;
                newFlags[flagV] = a == 8'h7F;
            end
            aluDec: begin
                res             = a - 8'd1;
                newFlags[flagV] = a == 8'h80;
            end
            aluOr: begin
                res             = a | b;
                newFlags[flagV] = 1'b0;
            end
            aluAnd, aluTm: begin
                res             = a & b;
                newFlags[flagV] = 1'b0;
            end
            aluTcm: begin
                res             = ~a & b;
                newFlags[flagV] = 1'b0;
            end
            aluXor: begin
                res             = a ^ b;
                newFlags[flagV] = 1'b0;
            end
            // carry ops leave everything but C alone
            aluSetCarry: begin
                newFlags[flagC] = 1'b1;
                setZs           = 1'b0;
            end
            aluClearCarry: begin
                newFlags[flagC] = 1'b0;
                setZs           = 1'b0;
            end
            aluComplementCarry: begin
                newFlags[flagC] = ~flags[flagC];
                setZs           = 1'b0;
            end
            default: setZs = 1'b0;
        endcase
        if (setZs) begin
            newFlags[flagZ] = res == 8'h00;
            newFlags[flagS] = res[7];
        end
        alu.result   = res;
        alu.flagsOut = newFlags;
    end
endmodule

`default_nettype wire

//--- common/aluIf.sv
`timescale 1ns/1ps
`default_nettype none

interface aluIf
    import z8CorePkg::*;
();
    aluModeT mode;
    byteT    operandA;
    byteT    operandB;
    byteT    result;
    byteT    flagsOut;

    // djnz looks at the result to decide the branch
    modport seq (output mode, operandA, operandB, input result);

    modport alu (input mode, operandA, operandB, output result, flagsOut);

    modport sink (input result, flagsOut);
endinterface

`default_nettype wire

//--- common/regFileIf.sv
`timescale 1ns/1ps
`default_nettype none

interface regFileIf
    import z8IsaPkg::*, z8CorePkg::*;
();
    regAddrT readAddrA;
    regAddrT readAddrB;
    byteT    readDataA;
    byteT    readDataB;
    logic    writeEnable;
    regAddrT writeAddr;
    logic    flagsWrite;
    byteT    flags;

    modport seq (
        output readAddrA, readAddrB, writeEnable, writeAddr, flagsWrite,
        input  readDataA, readDataB, flags
    );

    modport regs (
        input  readAddrA, readAddrB, writeEnable, writeAddr, flagsWrite,
        output readDataA, readDataB, flags
    );
endinterface

`default_nettype wire

//--- common/z8CorePkg.sv
`default_nettype none

package z8CorePkg;

    typedef logic [7:0]  byteT;
    typedef logic [15:0] pcT;

    // registers 0x00 to 0x7F
    localparam int numGeneralRegs = 128;

    typedef enum logic [2:0] {
        stFetch,
        stReadInstr,
        stWait2,
        stRead2,
        stWait3,
        stRead3,
        stDecode,
        stExecute
    } seqStateT;

    typedef enum logic [3:0] {
        aluLoad, aluInc, aluDec,
        aluAdd, aluAdc, aluSub, aluSbc,
        aluOr, aluAnd, aluTcm, aluTm, aluCp, aluXor,
        aluSetCarry, aluClearCarry, aluComplementCarry
    } aluModeT;

endpackage

`default_nettype wire

//--- common/z8IsaPkg.sv
`default_nettype none

package z8IsaPkg;

    typedef logic [7:0] regAddrT;

    // control registers at the top of the register space
    localparam regAddrT addrRp    = 8'hFD;
    localparam regAddrT addrFlags = 8'hFC;
    localparam regAddrT addrPort2 = 8'h02;

    // high nibble of an 8-bit address that points at a working register
    localparam logic [3:0] workingPrefix = 4'hE;

    // bit positions inside FLAGS
    localparam int flagC = 7;
    localparam int flagZ = 6;
    localparam int flagS = 5;
    localparam int flagV = 4;

    localparam logic [15:0] resetVector = 16'h000C;

    // branch conditions, the upper half is the inverse of the lower half
    typedef enum logic [3:0] {
        ccFalse, ccLt, ccLe, ccUle, ccOv, ccMi, ccZero, ccCarry,
        ccTrue, ccGe, ccGt, ccUgt, ccNoOv, ccPlus, ccNonZero, ccNoCarry
    } condCodeT;

    // opcode low nibbles that carry an instruction in this core
    typedef enum logic [3:0] {
        colSrp      = 4'h1,
        colAluReg   = 4'h2,
        colAluImm   = 4'h6,
        colLdRegDir = 4'h8,
        colLdDirReg = 4'h9,
        colDjnz     = 4'hA,
        colJr       = 4'hB,
        colLdImm    = 4'hC,
        colJp       = 4'hD,
        colInc      = 4'hE,
        colMisc     = 4'hF
    } columnT;

endpackage

`default_nettype wire
